/* design/usb_bit_sampler.sv */
`timescale 1ns/1ps

module usb_bit_sampler
    import usb_rx_pkg::*;
(
    input  logic     tb_clk,
    input  logic     tb_n_rst,
    input  logic     d_plus,
    input  logic     d_minus,
    output line_ev_t ev
);

    localparam int CNT_W  = $clog2(CLKS_PER_BIT);
    localparam int ONES_W = $clog2(STUFF_LIMIT + 1);

    logic [1:0]        dp_sync;
    logic [1:0]        dm_sync;
    logic              dp_prev;
    logic              dm_prev;
    logic [CNT_W-1:0]  clk_cnt;
    logic [ONES_W-1:0] ones_cnt;
    logic              last_dp;
    logic              se0_seen;
    logic              dp;
    logic              dm;
    logic              line_edge;
    logic              sample;
    logic              se0;
    logic              nrzi_bit;

    assign dp        = dp_sync[1];
    assign dm        = dm_sync[1];
    assign line_edge = (dp != dp_prev) || (dm != dm_prev);
    assign sample    = !line_edge && (clk_cnt == CNT_W'(SAMPLE_POINT - 1));
    assign se0       = !dp && !dm;
    assign nrzi_bit  = (dp == last_dp);  // No change means a one

    // ----------------------------------------------------------------------
    // Synchronizer and bit timing recovery
    // ----------------------------------------------------------------------
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            dp_sync <= 2'b11;  // Idle J
            dm_sync <= 2'b00;
            dp_prev <= 1'b1;
            dm_prev <= 1'b0;
            clk_cnt <= '0;
        end else begin
            dp_sync <= {dp_sync[0], d_plus};
            dm_sync <= {dm_sync[0], d_minus};
            dp_prev <= dp;
            dm_prev <= dm;
            if (line_edge || clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // NRZI decode, unstuffing, EOP
    // ----------------------------------------------------------------------
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            ev       <= '0;
            ones_cnt <= '0;
            last_dp  <= 1'b1;
            se0_seen <= 1'b0;
        end else begin
            ev.bit_valid <= 1'b0;
            ev.eop       <= 1'b0;
            ev.stuff_err <= 1'b0;
            if (sample) begin
                if (se0) begin
                    se0_seen <= 1'b1;
                    if (se0_seen && ev.active) begin
                        ev.eop    <= 1'b1;
                        ev.active <= 1'b0;
                    end
                end else begin
                    se0_seen <= 1'b0;
                    last_dp  <= dp;
                    if (!ev.active) begin
                        if (!dp) begin  // First K starts the sync field
                            ev.active    <= 1'b1;
                            ev.bit_valid <= 1'b1;
                            ev.bit_value <= 1'b0;
                            ones_cnt     <= '0;
                        end
                    end else if (ones_cnt == ONES_W'(STUFF_LIMIT)) begin
                        ones_cnt     <= '0;   // Stuffed zero dropped
                        ev.stuff_err <= nrzi_bit;
                    end else begin
                        ev.bit_valid <= 1'b1;
                        ev.bit_value <= nrzi_bit;
                        ones_cnt     <= nrzi_bit ? ones_cnt + 1'b1 : '0;
                    end
                end
            end
        end
    end

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        !(ev.bit_valid && ev.eop));

endmodule

/* design/usb_crc16.sv */
`timescale 1ns/1ps

module usb_crc16
    import usb_rx_pkg::*;
(
    input  logic     tb_clk,
    input  logic     tb_n_rst,
    input  line_ev_t ev,
    input  logic     crc_en,
    input  logic     crc_clear,
    output logic     crc_ok
);

    crc16_t crc;
    logic   fb;

    assign fb = crc[15] ^ ev.bit_value;

    // Serial update in wire order, payload then CRC field
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            crc <= '1;
        end else if (crc_clear) begin
            crc <= '1;
        end else if (crc_en && ev.bit_valid) begin
            crc <= {crc[14:0], 1'b0} ^ (fb ? CRC16_POLY : '0);
        end
    end

    assign crc_ok = (crc == CRC16_RESIDUE);

endmodule

/* design/usb_rx.sv */
`timescale 1ns/1ps

module usb_rx
    import usb_rx_pkg::*;
(
    input  logic       tb_clk,
    input  logic       tb_n_rst,
    input  logic       d_plus,
    input  logic       d_minus,
    input  logic       r_enable,
    output rx_packet_t rx_packet,
    output byte_t      rx_packet_data,
    output logic       store_rx_packet,
    output logic       packet_done,
    output logic       r_error
);

    line_ev_t ev;
    logic     byte_done;
    byte_t    rx_byte;
    logic     crc_en;
    logic     crc_clear;
    logic     crc_ok;

    usb_bit_sampler u_sampler (
        .tb_clk   (tb_clk),
        .tb_n_rst (tb_n_rst),
        .d_plus   (d_plus),
        .d_minus  (d_minus),
        .ev       (ev)
    );

    usb_rx_shift u_shift (
        .tb_clk    (tb_clk),
        .tb_n_rst  (tb_n_rst),
        .ev        (ev),
        .byte_done (byte_done),
        .rx_byte   (rx_byte)
    );

    usb_crc16 u_crc (
        .tb_clk    (tb_clk),
        .tb_n_rst  (tb_n_rst),
        .ev        (ev),
        .crc_en    (crc_en),
        .crc_clear (crc_clear),
        .crc_ok    (crc_ok)
    );

    usb_rx_ctrl u_ctrl (
        .tb_clk          (tb_clk),
        .tb_n_rst        (tb_n_rst),
        .r_enable        (r_enable),
        .ev              (ev),
        .byte_done       (byte_done),
        .rx_byte         (rx_byte),
        .crc_ok          (crc_ok),
        .crc_en          (crc_en),
        .crc_clear       (crc_clear),
        .rx_packet       (rx_packet),
        .rx_packet_data  (rx_packet_data),
        .store_rx_packet (store_rx_packet),
        .packet_done     (packet_done),
        .r_error         (r_error)
    );

endmodule

/* design/usb_rx_ctrl.sv */
`timescale 1ns/1ps

module usb_rx_ctrl
    import usb_rx_pkg::*;
(
    input  logic       tb_clk,
    input  logic       tb_n_rst,
    input  logic       r_enable,
    input  line_ev_t   ev,
    input  logic       byte_done,
    input  byte_t      rx_byte,
    input  logic       crc_ok,
    output logic       crc_en,
    output logic       crc_clear,
    output rx_packet_t rx_packet,
    output byte_t      rx_packet_data,
    output logic       store_rx_packet,
    output logic       packet_done,
    output logic       r_error
);

    rx_state_t  state;
    byte_t      hold_new;
    byte_t      hold_old;
    logic [1:0] byte_cnt;
    logic       partial;   // Bits since the last full byte
    logic       active_q;
    logic       pkt_start;
    logic       bad_end;
    rx_packet_t pid_pkt;

    function automatic rx_packet_t pid_code(byte_t pid);
        case (pid)
            PID_OUT:   return PKT_OUT;
            PID_IN:    return PKT_IN;
            PID_DATA0: return PKT_DATA0;
            PID_DATA1: return PKT_DATA1;
            PID_ACK:   return PKT_ACK;
            PID_NAK:   return PKT_NAK;
            default:   return PKT_UNSUP;
        endcase
    endfunction

    assign pkt_start = ev.active && !active_q;
    assign crc_en    = (state == DATA);
    assign crc_clear = (state == PID);
    assign pid_pkt   = pid_code(rx_byte);

    always_comb begin
        case (state)
            SYNC, PID, ERROR: bad_end = 1'b1;
            DATA:             bad_end = partial || (byte_cnt < 2'd2) || !crc_ok;
            default:          bad_end = partial;
        endcase
    end

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            active_q <= 1'b0;
            partial  <= 1'b0;
        end else begin
            active_q <= ev.active;
            if (byte_done || !ev.active) partial <= 1'b0;
            else if (ev.bit_valid)       partial <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Packet FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            state           <= IDLE;
            rx_packet       <= PKT_NONE;
            byte_cnt        <= '0;
            store_rx_packet <= 1'b0;
            rx_packet_data  <= '0;
            packet_done     <= 1'b0;
            r_error         <= 1'b0;
        end else begin
            store_rx_packet <= 1'b0;
            rx_packet_data  <= '0;
            packet_done     <= 1'b0;
            r_error         <= 1'b0;
            if (!r_enable) begin
                state <= IDLE;
            end else if (state == IDLE) begin
                if (pkt_start) begin
                    state     <= SYNC;
                    rx_packet <= PKT_NONE;
                end
            end else if (ev.eop) begin
                packet_done <= !bad_end;
                r_error     <= bad_end;
                state       <= IDLE;
            end else if (ev.stuff_err) begin
                state <= ERROR;
            end else if (byte_done) begin
                case (state)
                    SYNC: state <= (rx_byte == SYNC_BYTE) ? PID : IDLE;
                    PID: begin
                        byte_cnt <= '0;
                        if (rx_byte[7:4] != ~rx_byte[3:0]) begin
                            state <= ERROR;  // Check nibble mismatch
                        end else begin
                            rx_packet <= pid_pkt;
                            case (pid_pkt)
                                PKT_OUT, PKT_IN:     state <= TOKEN;
                                PKT_DATA0, PKT_DATA1: state <= DATA;
                                default:             state <= WAIT_EOP;
                            endcase
                        end
                    end
                    TOKEN: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd1) state <= WAIT_EOP;  // Address and endpoint
                    end
                    DATA: begin
                        if (byte_cnt == 2'd2) begin
                            store_rx_packet <= 1'b1;
                            rx_packet_data  <= hold_old;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Two-byte delay keeps the CRC out of the store stream
    always_ff @(posedge tb_clk) begin
        if (byte_done && state == DATA) begin
            hold_old <= hold_new;
            hold_new <= rx_byte;
        end
    end

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        store_rx_packet |-> !(packet_done || r_error));

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        !(packet_done && r_error));

endmodule

/* design/usb_rx_pkg.sv */
package usb_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  rx_packet_t;
    typedef logic [15:0] crc16_t;

    // ----------------------------------------------------------------------
    // Line timing
    // ----------------------------------------------------------------------
    localparam int CLKS_PER_BIT = 8;
    localparam int SAMPLE_POINT = 4;   // Clocks after an edge
    localparam int STUFF_LIMIT  = 6;

    // ----------------------------------------------------------------------
    // Protocol values, bytes as seen LSB first on the wire
    // ----------------------------------------------------------------------
    localparam byte_t SYNC_BYTE = 8'h80;
    localparam byte_t PID_OUT   = 8'hE1;
    localparam byte_t PID_IN    = 8'h69;
    localparam byte_t PID_DATA0 = 8'hC3;
    localparam byte_t PID_DATA1 = 8'h4B;
    localparam byte_t PID_ACK   = 8'hD2;
    localparam byte_t PID_NAK   = 8'h5A;

    // Packet codes on rx_packet
    localparam rx_packet_t PKT_NONE  = 3'd0;
    localparam rx_packet_t PKT_OUT   = 3'd1;
    localparam rx_packet_t PKT_IN    = 3'd2;
    localparam rx_packet_t PKT_DATA0 = 3'd3;
    localparam rx_packet_t PKT_DATA1 = 3'd4;
    localparam rx_packet_t PKT_ACK   = 3'd5;
    localparam rx_packet_t PKT_NAK   = 3'd6;
    localparam rx_packet_t PKT_UNSUP = 3'd7;

    localparam crc16_t CRC16_POLY    = 16'h8005;
    localparam crc16_t CRC16_RESIDUE = 16'h800D;  // Remainder of a good packet

    typedef enum logic [2:0] {
        IDLE, SYNC, PID, TOKEN, DATA, WAIT_EOP, ERROR
    } rx_state_t;

    // Decoded line events, one bit per cycle at most
    typedef struct packed {
        logic bit_valid;
        logic bit_value;
        logic eop;
        logic stuff_err;
        logic active;     // Packet in progress
    } line_ev_t;

endpackage

/* design/usb_rx_shift.sv */
`timescale 1ns/1ps

module usb_rx_shift
    import usb_rx_pkg::*;
(
    input  logic     tb_clk,
    input  logic     tb_n_rst,
    input  line_ev_t ev,
    output logic     byte_done,
    output byte_t    rx_byte
);

    logic [2:0] bit_cnt;
    logic [6:0] shreg;  // First seven bits of the byte

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (!ev.active) begin
                bit_cnt <= '0;  // Realign for the next packet
            end else if (ev.bit_valid) begin
                bit_cnt   <= bit_cnt + 1'b1;
                byte_done <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge tb_clk) begin
        if (ev.bit_valid) begin
            shreg <= {ev.bit_value, shreg[6:1]};
            if (bit_cnt == 3'd7) rx_byte <= {ev.bit_value, shreg};
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f usb_rx.f --top-module tb_usb_rx -o sim_usb_rx

# The simulator exits non-zero on $fatal, the log decides the verdict
./obj_dir/sim_usb_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "All checks passed" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation PASSED"

/* usb_rx.f */
design/usb_rx_pkg.sv
design/usb_bit_sampler.sv
design/usb_rx_shift.sv
design/usb_crc16.sv
design/usb_rx_ctrl.sv
design/usb_rx.sv
verification/tb_usb_rx.sv

/* verification/tb_usb_rx.sv */
`timescale 1ns/1ps

module tb_usb_rx
    import usb_rx_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int SLACK_CYCLES = 200;

    logic       tb_clk;
    logic       tb_n_rst;
    logic       d_plus;
    logic       d_minus;
    logic       r_enable;
    rx_packet_t rx_packet;
    byte_t      rx_packet_data;
    logic       store_rx_packet;
    logic       packet_done;
    logic       r_error;

    byte_t       tx_bytes[$];   // Bytes on the wire, sync first
    byte_t       payload[$];
    byte_t       exp_q[$];
    byte_t       got_q[$];
    rx_packet_t  exp_packet;
    logic        exp_done;
    int          ends_seen = 0;
    int          bits_sent = 0;  // Stuffed and EOP bits included
    int          cycle_cnt = 0;
    logic [31:0] rng = 32'ha119_187a;

    usb_rx uut (.*);

    always #20 tb_clk = ~tb_clk;

    // ----------------------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------------------
    function automatic logic [15:0] usb_crc16_ref(input byte_t data[$]);
        logic [15:0] crc;
        crc = 16'hFFFF;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ data[i][b])
                    crc = (crc >> 1) ^ 16'hA001;  // Reflected x^16+x^15+x^2+1
                else
                    crc = crc >> 1;
            end
        end
        return ~crc;  // Low byte goes out first
    endfunction

    function automatic rx_packet_t expected_packet_code(input byte_t pid);
        case (pid)
            PID_OUT:   return 3'd1;
            PID_IN:    return 3'd2;
            PID_DATA0: return 3'd3;
            PID_DATA1: return 3'd4;
            PID_ACK:   return 3'd5;
            PID_NAK:   return 3'd6;
            default:   return 3'd7;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
            fail_now($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_packet(input rx_packet_t got, input rx_packet_t exp);
        if (got !== exp)
            fail_now($sformatf("Mismatch rx_packet: got 0x%h, expected 0x%h", got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // ----------------------------------------------------------------------
    // Line driver and packet builders
    // ----------------------------------------------------------------------
    task automatic line_bit(input logic dp, input logic dm);
        d_plus  = dp;
        d_minus = dm;
        bits_sent++;
        repeat (CLKS_PER_BIT) @(negedge tb_clk);
    endtask

    task automatic drive_packet(input logic skip_stuff);
        int   ones;
        logic level;
        logic skipped;
        ones    = 0;
        level   = 1'b1;  // Idle J
        skipped = 1'b0;
        foreach (tx_bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                if (!tx_bytes[i][b])
                    level = !level;  // NRZI zero toggles
                line_bit(level, !level);
                ones = tx_bytes[i][b] ? ones + 1 : 0;
                if (ones == STUFF_LIMIT) begin
                    ones = 0;
                    if (skip_stuff && !skipped) begin
                        skipped = 1'b1;
                    end else begin
                        level = !level;
                        line_bit(level, !level);
                    end
                end
            end
        end
        line_bit(1'b0, 1'b0);  // SE0 for two bits
        line_bit(1'b0, 1'b0);
        repeat (3) line_bit(1'b1, 1'b0);
    endtask

    task automatic build_data(input byte_t pid, input logic flip);
        logic [15:0] crc;
        crc = usb_crc16_ref(payload);
        if (flip)
            payload[0] = payload[0] ^ 8'h10;  // Corrupted after the CRC is fixed
        tx_bytes = {SYNC_BYTE, pid};
        foreach (payload[i])
            tx_bytes.push_back(payload[i]);
        tx_bytes.push_back(crc[7:0]);
        tx_bytes.push_back(crc[15:8]);
        exp_q      = payload;
        exp_packet = expected_packet_code(pid);
        exp_done   = !flip;
    endtask

    task automatic build_short(input byte_t pid, input int extra);
        tx_bytes = {SYNC_BYTE, pid};
        for (int i = 0; i < extra; i++) begin
            rng = xorshift32(rng);
            tx_bytes.push_back(rng[7:0]);
        end
        exp_q.delete();
        exp_packet = expected_packet_code(pid);
        exp_done   = 1'b1;
    endtask

    task automatic run_packet(input logic skip_stuff);
        int ends_before;
        ends_before = ends_seen;
        drive_packet(skip_stuff);
        while (ends_seen == ends_before)
            @(negedge tb_clk);
    endtask

    // ----------------------------------------------------------------------
    // Monitor and timeout
    // ----------------------------------------------------------------------
    always @(negedge tb_clk) begin
        if (tb_n_rst) begin
            if (store_rx_packet)
                got_q.push_back(rx_packet_data);
            else
                check_byte("rx_packet_data", rx_packet_data, 8'h00);
            if (!r_enable && (store_rx_packet || packet_done || r_error))
                fail_now("Strobe seen while r_enable is low");
            if (packet_done || r_error) begin
                check_packet(rx_packet, exp_packet);
                check_flag("packet_done", packet_done, exp_done);
                check_flag("r_error", r_error, !exp_done);
                if (got_q.size() != exp_q.size())
                    fail_now($sformatf("Wrong number of stored bytes: got %0d, expected %0d",
                        got_q.size(), exp_q.size()));
                foreach (exp_q[i])
                    check_byte("rx_packet_data", got_q[i], exp_q[i]);
                got_q.delete();
                ends_seen++;
            end
        end
    end

    always @(posedge tb_clk) begin
        cycle_cnt++;
        if (cycle_cnt > bits_sent * CLKS_PER_BIT + RESET_CYCLES + SLACK_CYCLES)
            fail_now("Timeout while waiting for the end of a packet");
    end

    initial begin
        int len;
        tb_clk   = 1'b0;
        tb_n_rst = 1'b0;
        d_plus   = 1'b1;
        d_minus  = 1'b0;
        r_enable = 1'b1;
        repeat (RESET_CYCLES) @(negedge tb_clk);
        tb_n_rst = 1'b1;
        check_packet(rx_packet, 3'd0);
        check_flag("store_rx_packet", store_rx_packet, 1'b0);
        check_flag("packet_done", packet_done, 1'b0);
        check_flag("r_error", r_error, 1'b0);

        payload = {8'h00, 8'h01, 8'h02, 8'h03};
        build_data(PID_DATA0, 1'b0);
        run_packet(1'b0);

        for (int n = 0; n < 20; n++) begin
            rng = xorshift32(rng);
            len = int'(rng % 17);
            if (n % 4 == 3 && len < 2)
                len = 2;
            payload.delete();
            for (int i = 0; i < len; i++) begin
                rng = xorshift32(rng);
                payload.push_back((n % 4 == 3 || rng[15:13] == 3'd0) ? 8'hFF : rng[7:0]);
            end
            build_data(rng[20] ? PID_DATA1 : PID_DATA0, 1'b0);
            run_packet(1'b0);
        end

        payload = {8'h5A, 8'h3C, 8'h99, 8'h00};
        build_data(PID_DATA1, 1'b1);
        run_packet(1'b0);

        build_short(PID_DATA0 ^ 8'h01, 2);
        exp_packet = 3'd0;  // Code stays cleared after a bad check nibble
        exp_done   = 1'b0;
        run_packet(1'b0);

        build_short(PID_ACK, 0);
        run_packet(1'b0);
        build_short(PID_NAK, 0);
        run_packet(1'b0);
        build_short(PID_IN, 2);
        run_packet(1'b0);
        build_short(PID_OUT, 2);
        run_packet(1'b0);

        // Stuffed zero left out inside the first payload byte
        payload = {8'hFF, 8'hFF, 8'hFF};
        build_data(PID_DATA0, 1'b0);
        exp_q.delete();
        exp_done = 1'b0;
        run_packet(1'b1);

        r_enable = 1'b0;
        payload  = {8'h11, 8'h22, 8'h33};
        build_data(PID_DATA0, 1'b0);
        drive_packet(1'b0);
        r_enable = 1'b1;
        payload  = {8'hA5, 8'hFF};
        build_data(PID_DATA1, 1'b0);
        run_packet(1'b0);

        $display("All checks passed");
        $finish;
    end

endmodule
